// ==== flist.f ====
design/vga_pkg.sv
design/video_timing.sv
design/host_regs.sv
design/tile_pattern.sv
design/color_compose.sv
design/channel_dither.sv
design/vga_out.sv
design/gameduino_video.sv
test/tb_gameduino_video.sv

// ==== test/tb_gameduino_video.sv ====
`timescale 1ns/1ps

module tb_gameduino_video
  import vga_pkg::*;
();

  localparam int H_TOTAL        = 40;
  localparam int H_ACTIVE       = 16;
  localparam int H_SYNC_START   = 22;
  localparam int H_SYNC_LEN     = 6;
  localparam int V_TOTAL        = 20;
  localparam int V_ACTIVE_START = 6;
  localparam int V_ACTIVE       = 10;
  localparam int V_SYNC_START   = 2;
  localparam int V_SYNC_LEN     = 2;

  localparam int FRAME        = H_TOTAL * V_TOTAL;
  localparam int CLK_NS       = 20;
  localparam int N_ROWS       = 4;
  localparam int CHECK_CYCLES = FRAME + 3 * H_TOTAL;
  localparam int PROBE_H      = H_ACTIVE - 1;
  localparam int WATCHDOG_NS  = N_ROWS * 3 * FRAME * CLK_NS + 2 * FRAME * CLK_NS;

  // stimulus row with the expected {r, g, b} at the probe pixel
  typedef struct packed {
    logic             rand_tile;
    logic [7:0]       tile_fill;
    logic [14:0]      bg;
    logic [3:0][15:0] glob;
    logic [1:0]       dith;
    logic [8:0]       probe;
  } row_t;

  logic       vga_clk;
  logic       arst_n_i;
  host_bus_t  host;
  byte_t      host_rdata;
  chan3_t     vga_red;
  chan3_t     vga_green;
  chan3_t     vga_blue;
  logic       vga_hsync_n;
  logic       vga_vsync_n;

  int   seed;
  int   cyc;
  int   errors;
  int   pass_count;
  int   fail_count;
  int   errors_before;
  row_t rows [N_ROWS];
  string row_names [N_ROWS] = '{"tile palette", "transparency", "dither saturation",
                                "dither x only"};
  host_addr_t status_addrs [4] = '{REG_FRAMES, REG_VBLANK, REG_YY_L, REG_YY_H};

  // reference copy of the programmed state
  logic [14:0]      m_bg;
  logic [3:0][15:0] m_glob;
  logic [1:0]       m_dith;
  logic [7:0]       m_tile [16];

  gameduino_video #(
    .H_TOTAL        (H_TOTAL),
    .H_ACTIVE       (H_ACTIVE),
    .H_SYNC_START   (H_SYNC_START),
    .H_SYNC_LEN     (H_SYNC_LEN),
    .V_TOTAL        (V_TOTAL),
    .V_ACTIVE_START (V_ACTIVE_START),
    .V_ACTIVE       (V_ACTIVE),
    .V_SYNC_START   (V_SYNC_START),
    .V_SYNC_LEN     (V_SYNC_LEN)
  ) DUT (
    .vga_clk       (vga_clk),
    .arst_n_i      (arst_n_i),
    .host_i        (host),
    .host_rdata_o  (host_rdata),
    .vga_red_o     (vga_red),
    .vga_green_o   (vga_green),
    .vga_blue_o    (vga_blue),
    .vga_hsync_n_o (vga_hsync_n),
    .vga_vsync_n_o (vga_vsync_n)
  );

  initial
  begin
    vga_clk = 1'b0;
    forever #(CLK_NS / 2) vga_clk = ~vga_clk;
  end

  // counter state index since reset release
  always @(posedge vga_clk)
  begin
    if (arst_n_i)
      cyc <= cyc + 1;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic host_write(input host_addr_t addr, input byte_t data);
    @(posedge vga_clk);
    host.wr    <= 1'b1;
    host.waddr <= addr;
    host.wdata <= data;
    @(posedge vga_clk);
    host.wr    <= 1'b0;
  endtask

  task automatic read_expect(input host_addr_t addr, input byte_t exp);
    @(posedge vga_clk);
    host.raddr <= addr;
    @(negedge vga_clk);
    compare_value($sformatf("host_rdata_o[%02h]", addr), host_rdata, exp);
  endtask

  // frame count, blanking and line number from the raster rules
  function automatic byte_t status_value(input host_addr_t addr, input int n);
    int         v;
    logic       blank;
    logic [8:0] yy9;
    v     = (n / H_TOTAL) % V_TOTAL;
    blank = (v < V_ACTIVE_START) || (v >= V_ACTIVE_START + V_ACTIVE);
    yy9   = blank ? 9'd300 : 9'((v - V_ACTIVE_START) / 2);
    case (addr)
      REG_FRAMES:
        return byte_t'(n / FRAME);
      REG_VBLANK:
        return {7'b0, blank};
      REG_YY_L:
        return yy9[7:0];
      default:
        return {7'b0, yy9[8]};
    endcase
  endfunction

  task automatic read_status(input host_addr_t addr);
    @(posedge vga_clk);
    host.raddr <= addr;
    @(negedge vga_clk);
    compare_value($sformatf("host_rdata_o[%02h]", addr), host_rdata, status_value(addr, cyc));
  endtask

  // expected {hsync_n, vsync_n, r, g, b} for counter state n
  function automatic logic [10:0] model_pins(input int n);
    int          h;
    int          v;
    int          yy;
    int          s;
    int          c;
    logic        hs;
    logic        vs;
    logic        act;
    logic        xp;
    logic        yp;
    logic [7:0]  tbyte;
    logic [1:0]  idx;
    logic [1:0]  dth;
    logic [15:0] matte;
    logic [14:0] rgb;
    logic [8:0]  chans;
    h     = n % H_TOTAL;
    v     = (n / H_TOTAL) % V_TOTAL;
    yy    = v - V_ACTIVE_START;
    hs    = (h >= H_SYNC_START) && (h < H_SYNC_START + H_SYNC_LEN);
    vs    = (v >= V_SYNC_START) && (v < V_SYNC_START + V_SYNC_LEN);
    act   = (yy >= 0) && (yy < V_ACTIVE) && (h < H_ACTIVE);
    chans = '0;
    if (act)
    begin
      // tile repeats every 16 screen pixels with field 0 leftmost
      tbyte = m_tile[((yy / 2) % 8) * 2 + ((h / 2) % 8) / 4];
      idx   = 2'(tbyte >> (6 - 2 * ((h / 2) % 4)));
      matte = m_glob[idx];
      rgb   = matte[15] ? m_bg : matte[14:0];
      xp    = (h % 2) == 1;
      yp    = (yy % 2) == 1;
      dth   = {(xp & m_dith[0]) ^ (yp & m_dith[1]), yp & m_dith[1]};
      for (c = 0; c < 3; c++)
      begin
        s = ((rgb >> (10 - 5 * c)) & 15'h1f) + dth;
        chans[8 - 3 * c -: 3] = (s > 31) ? 3'd7 : 3'(s / 4);
      end
    end
    return {~hs, ~vs, chans};
  endfunction

  task automatic apply_row(input row_t row);
    byte_t tbyte;
    int    i;
    for (i = 0; i < 16; i++)
    begin
      tbyte = row.rand_tile ? byte_t'($random(seed)) : row.tile_fill;
      // probe pixel always uses palette index 3
      if (i == 1)
        tbyte[1:0] = 2'b11;
      m_tile[i] = tbyte;
      host_write(TILE_BASE + host_addr_t'(i), tbyte);
    end
    m_bg   = row.bg;
    m_glob = row.glob;
    m_dith = row.dith;
    host_write(REG_BG_L, row.bg[7:0]);
    host_write(REG_BG_H, {1'b0, row.bg[14:8]});
    for (i = 0; i < 4; i++)
    begin
      host_write(REG_G0_L + host_addr_t'(2 * i), row.glob[i][7:0]);
      host_write(REG_G0_L + host_addr_t'(2 * i + 1), row.glob[i][15:8]);
    end
    host_write(REG_DITH, {6'b0, row.dith});
    for (i = 0; i < 16; i++)
      read_expect(TILE_BASE + host_addr_t'(i), m_tile[i]);
    read_expect(REG_BG_L, row.bg[7:0]);
    read_expect(REG_BG_H, {1'b0, row.bg[14:8]});
    for (i = 0; i < 4; i++)
    begin
      read_expect(REG_G0_L + host_addr_t'(2 * i), row.glob[i][7:0]);
      read_expect(REG_G0_L + host_addr_t'(2 * i + 1), row.glob[i][15:8]);
    end
    read_expect(REG_DITH, {6'b0, row.dith});
  endtask

  task automatic run_frame_checks(input row_t row);
    int          k;
    int          n;
    int          hs_len;
    int          vs_len;
    int          vs_pulses;
    logic        hs_armed;
    logic        vs_armed;
    logic [10:0] exp_pins;
    hs_len    = 0;
    vs_len    = 0;
    vs_pulses = 0;
    hs_armed  = 1'b0;
    vs_armed  = 1'b0;
    for (k = 0; k < CHECK_CYCLES; k++)
    begin
      read_status(status_addrs[k % 4]);
      // pins lag the counters by three cycles
      n        = (cyc >= 3) ? cyc - 3 : 0;
      exp_pins = model_pins(n);
      compare_value("vga_hsync_n_o", vga_hsync_n, exp_pins[10]);
      compare_value("vga_vsync_n_o", vga_vsync_n, exp_pins[9]);
      compare_value("vga_red_o", vga_red, exp_pins[8:6]);
      compare_value("vga_green_o", vga_green, exp_pins[5:3]);
      compare_value("vga_blue_o", vga_blue, exp_pins[2:0]);
      if ((n % H_TOTAL == PROBE_H) && ((n / H_TOTAL) % V_TOTAL == V_ACTIVE_START))
        compare_value("probe rgb", {vga_red, vga_green, vga_blue}, row.probe);
      // partial pulses at the window start are skipped
      if (!vga_hsync_n)
        hs_len++;
      else
      begin
        if (hs_armed && hs_len > 0)
          compare_value("hsync low cycles", hs_len, H_SYNC_LEN);
        hs_armed = 1'b1;
        hs_len   = 0;
      end
      if (!vga_vsync_n)
        vs_len++;
      else
      begin
        if (vs_armed && vs_len > 0)
        begin
          compare_value("vsync low cycles", vs_len, V_SYNC_LEN * H_TOTAL);
          vs_pulses++;
        end
        vs_armed = 1'b1;
        vs_len   = 0;
      end
    end
    if (vs_pulses == 0)
    begin
      errors++;
      $display("no complete vsync pulse was seen during the frame check");
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (errors == errs_at_start)
    begin
      pass_count++;
      $display("test %-20s ok", name);
    end
    else
    begin
      fail_count++;
      $display("test %-20s failed with %0d errors", name, errors - errs_at_start);
    end
  endtask

  initial
  begin
    seed       = 32'h774d;
    cyc        = 0;
    errors     = 0;
    pass_count = 0;
    fail_count = 0;
    host       = '0;
    arst_n_i   = 1'b0;

    rows[0] = {1'b1, 8'h00, 15'h1234, {16'h2d6b, 16'h001f, 16'h03e0, 16'h7c00}, 2'b00,
               {3'd2, 3'd2, 3'd2}};
    rows[1] = {1'b1, 8'h00, 15'h511f, {16'h8421, 16'h801f, 16'h03e0, 16'hfc00}, 2'b00,
               {3'd5, 3'd2, 3'd7}};
    rows[2] = {1'b1, 8'h00, 15'h0000, {16'h67c5, 16'h739c, 16'h7bde, 16'h7fff}, 2'b11,
               {3'd6, 3'd7, 3'd1}};
    rows[3] = {1'b0, 8'h1b, 15'h3def, {16'h0443, 16'h8000, 16'h5294, 16'h0000}, 2'b01,
               {3'd0, 3'd1, 3'd1}};

    // outputs idle while reset is held
    errors_before = errors;
    repeat (5)
    begin
      @(posedge vga_clk);
      @(negedge vga_clk);
      compare_value("vga_hsync_n_o", vga_hsync_n, 1'b1);
      compare_value("vga_vsync_n_o", vga_vsync_n, 1'b1);
      compare_value("vga_red_o", vga_red, 3'd0);
      compare_value("vga_green_o", vga_green, 3'd0);
      compare_value("vga_blue_o", vga_blue, 3'd0);
    end
    @(posedge vga_clk);
    arst_n_i <= 1'b1;

    read_expect(REG_IDENT, 8'h6d);
    read_expect(REG_REV, REVISION_VALUE);
    read_expect(6'h04, 8'hff);
    read_expect(6'h10, 8'hff);
    read_expect(6'h3f, 8'hff);
    read_expect(REG_BG_L, 8'hf4);
    read_expect(REG_BG_H, 8'h20);
    read_expect(REG_G0_L, 8'hff);
    read_expect(REG_G0_L + 6'd1, 8'hff);
    for (int i = 1; i < 4; i++)
    begin
      read_expect(REG_G0_L + host_addr_t'(2 * i), 8'h00);
      read_expect(REG_G0_L + host_addr_t'(2 * i + 1), 8'h80);
    end
    read_expect(REG_DITH, 8'h03);
    for (int i = 0; i < 16; i++)
      read_expect(TILE_BASE + host_addr_t'(i), 8'h00);
    for (int i = 0; i < 4; i++)
      read_status(status_addrs[i]);
    report_test("reset and defaults", errors_before);

    for (int r = 0; r < N_ROWS; r++)
    begin
      errors_before = errors;
      apply_row(rows[r]);
      run_frame_checks(rows[r]);
      report_test(row_names[r], errors_before);
    end

    $display("tests ok %0d, tests failed %0d, mismatches %0d", pass_count, fail_count, errors);
    if (fail_count == 0 && errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== design/gameduino_video.sv ====
`timescale 1ns/1ps

module gameduino_video
  import vga_pkg::*;
#(
  parameter int H_TOTAL        = 1040,
  parameter int H_ACTIVE       = 800,
  parameter int H_SYNC_START   = 861,
  parameter int H_SYNC_LEN     = 120,
  parameter int V_TOTAL        = 666,
  parameter int V_ACTIVE_START = 63,
  parameter int V_ACTIVE       = 600,
  parameter int V_SYNC_START   = 35,
  parameter int V_SYNC_LEN     = 6
)
(
  input  logic      vga_clk,
  input  logic      arst_n_i,
  input  host_bus_t host_i,
  output byte_t     host_rdata_o,
  output chan3_t    vga_red_o,
  output chan3_t    vga_green_o,
  output chan3_t    vga_blue_o,
  output logic      vga_hsync_n_o,
  output logic      vga_vsync_n_o
);

  timing_t    timing;
  byte_t      frames;
  logic       vblank;
  logic [8:0] public_yy;
  byte_t      tile_rdata;
  palette_t   palette;
  pixel_t     pixel;
  chan5_t     chan5 [3];
  chan3_t     chan3 [3];
  dith_t      dith;

  video_timing #(
    .H_TOTAL        (H_TOTAL),
    .H_ACTIVE       (H_ACTIVE),
    .H_SYNC_START   (H_SYNC_START),
    .H_SYNC_LEN     (H_SYNC_LEN),
    .V_TOTAL        (V_TOTAL),
    .V_ACTIVE_START (V_ACTIVE_START),
    .V_ACTIVE       (V_ACTIVE),
    .V_SYNC_START   (V_SYNC_START),
    .V_SYNC_LEN     (V_SYNC_LEN)
  ) u_timing (
    .vga_clk     (vga_clk),
    .arst_n_i    (arst_n_i),
    .timing_o    (timing),
    .frames_o    (frames),
    .vblank_o    (vblank),
    .public_yy_o (public_yy)
  );

  host_regs u_regs (
    .vga_clk      (vga_clk),
    .arst_n_i     (arst_n_i),
    .host_i       (host_i),
    .frames_i     (frames),
    .vblank_i     (vblank),
    .public_yy_i  (public_yy),
    .tile_rdata_i (tile_rdata),
    .palette_o    (palette),
    .host_rdata_o (host_rdata_o)
  );

  tile_pattern u_tile (
    .vga_clk      (vga_clk),
    .arst_n_i     (arst_n_i),
    .host_i       (host_i),
    .timing_i     (timing),
    .pixel_o      (pixel),
    .tile_rdata_o (tile_rdata)
  );

  color_compose u_compose (
    .pixel_i   (pixel),
    .palette_i (palette),
    .chan_o    (chan5),
    .dith_o    (dith)
  );

  // red, green, blue
  for (genvar i = 0; i < 3; i++)
  begin : g_chan
    channel_dither u_dither (
      .vga_clk  (vga_clk),
      .arst_n_i (arst_n_i),
      .chan_i   (chan5[i]),
      .dith_i   (dith),
      .chan_o   (chan3[i])
    );
  end

  vga_out u_out (
    .vga_clk       (vga_clk),
    .arst_n_i      (arst_n_i),
    .timing_i      (timing),
    .chan_i        (chan3),
    .vga_red_o     (vga_red_o),
    .vga_green_o   (vga_green_o),
    .vga_blue_o    (vga_blue_o),
    .vga_hsync_n_o (vga_hsync_n_o),
    .vga_vsync_n_o (vga_vsync_n_o)
  );

endmodule

// ==== design/vga_out.sv ====
`timescale 1ns/1ps

module vga_out
  import vga_pkg::*;
(
  input  logic    vga_clk,
  input  logic    arst_n_i,
  input  timing_t timing_i,
  input  chan3_t  chan_i [3],
  output chan3_t  vga_red_o,
  output chan3_t  vga_green_o,
  output chan3_t  vga_blue_o,
  output logic    vga_hsync_n_o,
  output logic    vga_vsync_n_o
);

  // {hsync, vsync, active}, two stages to match the colour path
  logic [2:0] flag_d1;
  logic [2:0] flag_d2;

  always_ff @(posedge vga_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      flag_d1       <= '0;
      flag_d2       <= '0;
      vga_red_o     <= '0;
      vga_green_o   <= '0;
      vga_blue_o    <= '0;
      vga_hsync_n_o <= 1'b1;
      vga_vsync_n_o <= 1'b1;
    end
    else
    begin
      flag_d1 <= {timing_i.hsync, timing_i.vsync, timing_i.active};
      flag_d2 <= flag_d1;

      // black outside the visible area
      vga_red_o   <= flag_d2[0] ? chan_i[0] : '0;
      vga_green_o <= flag_d2[0] ? chan_i[1] : '0;
      vga_blue_o  <= flag_d2[0] ? chan_i[2] : '0;

      vga_hsync_n_o <= ~flag_d2[2];
      vga_vsync_n_o <= ~flag_d2[1];
    end
  end

endmodule

// ==== design/channel_dither.sv ====
`timescale 1ns/1ps

module channel_dither
  import vga_pkg::*;
(
  input  logic   vga_clk,
  input  logic   arst_n_i,
  input  chan5_t chan_i,
  input  dith_t  dith_i,
  output chan3_t chan_o
);

  logic [5:0] sum;
  chan3_t     reduced;
  chan3_t     chan_q;

  assign sum = {1'b0, chan_i} + {4'b0, dith_i};

  // clamp on carry out, otherwise drop the two low bits
  assign reduced = sum[5] ? 3'b111 : sum[4:2];

  always_ff @(posedge vga_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      chan_q <= '0;
    else
      chan_q <= reduced;
  end

  assign chan_o = chan_q;

endmodule

// ==== design/color_compose.sv ====
`timescale 1ns/1ps

module color_compose
  import vga_pkg::*;
(
  input  pixel_t   pixel_i,
  input  palette_t palette_i,
  output chan5_t   chan_o [3],
  output dith_t    dith_o
);

  matte16_t matte;
  color15_t color;
  logic     x_dith;
  logic     y_dith;

  assign matte = palette_i.glob[pixel_i.idx];

  // transparent entries fall through to the background
  assign color = matte[15] ? palette_i.bg : matte[14:0];

  assign chan_o[0] = color[14:10];
  assign chan_o[1] = color[9:5];
  assign chan_o[2] = color[4:0];

  // 2x2 ordered pattern
  //   0 2
  //   3 1
  assign x_dith = pixel_i.x_par & palette_i.dith_en[0];
  assign y_dith = pixel_i.y_par & palette_i.dith_en[1];
  assign dith_o = {x_dith ^ y_dith, y_dith};

endmodule

// ==== design/tile_pattern.sv ====
`timescale 1ns/1ps

module tile_pattern
  import vga_pkg::*;
(
  input  logic      vga_clk,
  input  logic      arst_n_i,
  input  host_bus_t host_i,
  input  timing_t   timing_i,
  output pixel_t    pixel_o,
  output byte_t     tile_rdata_o
);

  byte_t [15:0] tile_q;
  logic  [3:0]  sel_addr;
  byte_t        sel_byte;
  pix_idx_t     pix_next;
  pixel_t       pixel_q;

  // 8x8 tile, two bytes per row
  always_ff @(posedge vga_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      tile_q <= '0;
    else if (host_i.wr && (host_i.waddr[5:4] == TILE_BASE[5:4]))
      tile_q[host_i.waddr[3:0]] <= host_i.wdata;
  end

  assign tile_rdata_o = tile_q[host_i.raddr[3:0]];

  assign sel_addr = {timing_i.row[2:0], timing_i.col[2]};
  assign sel_byte = tile_q[sel_addr];
  // leftmost pixel sits in the top two bits
  assign pix_next = sel_byte[{~timing_i.col[1:0], 1'b1} -: 2];

  always_ff @(posedge vga_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pixel_q <= '0;
    end
    else
    begin
      pixel_q.idx   <= pix_next;
      pixel_q.x_par <= timing_i.x_par;
      pixel_q.y_par <= timing_i.y_par;
    end
  end

  assign pixel_o = pixel_q;

endmodule

// ==== design/host_regs.sv ====
`timescale 1ns/1ps

module host_regs
  import vga_pkg::*;
(
  input  logic       vga_clk,
  input  logic       arst_n_i,
  input  host_bus_t  host_i,
  input  byte_t      frames_i,
  input  logic       vblank_i,
  input  logic [8:0] public_yy_i,
  input  byte_t      tile_rdata_i,
  output palette_t   palette_o,
  output byte_t      host_rdata_o
);

  color15_t       bg_q;
  matte16_t [3:0] glob_q;
  logic     [1:0] dith_q;
  host_addr_t     g_woff;
  host_addr_t     g_roff;

  // offsets into the global colour block, two bytes per entry
  assign g_woff = host_i.waddr - REG_G0_L;
  assign g_roff = host_i.raddr - REG_G0_L;

  always_ff @(posedge vga_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      bg_q   <= BG_RESET;
      glob_q <= GLOB_RESET;
      dith_q <= DITH_RESET;
    end
    else if (host_i.wr)
    begin
      case (host_i.waddr) inside
        REG_DITH:
          dith_q <= host_i.wdata[1:0];
        REG_BG_L:
          bg_q[7:0] <= host_i.wdata;
        REG_BG_H:
          bg_q[14:8] <= host_i.wdata[6:0];
        [REG_G0_L:REG_G3_H]:
        begin
          if (g_woff[0])
            glob_q[g_woff[2:1]][15:8] <= host_i.wdata;
          else
            glob_q[g_woff[2:1]][7:0] <= host_i.wdata;
        end
        default:
        begin
          // read-only or tile address, nothing stored here
        end
      endcase
    end
  end

  assign palette_o.bg      = bg_q;
  assign palette_o.glob    = glob_q;
  assign palette_o.dith_en = dith_q;

  // combinational read-back
  always_comb
  begin
    case (host_i.raddr) inside
      REG_IDENT:
        host_rdata_o = IDENT_VALUE;
      REG_REV:
        host_rdata_o = REVISION_VALUE;
      REG_FRAMES:
        host_rdata_o = frames_i;
      REG_VBLANK:
        host_rdata_o = {7'b0, vblank_i};
      REG_DITH:
        host_rdata_o = {6'b0, dith_q};
      REG_BG_L:
        host_rdata_o = bg_q[7:0];
      REG_BG_H:
        host_rdata_o = {1'b0, bg_q[14:8]};
      [REG_G0_L:REG_G3_H]:
      begin
        if (g_roff[0])
          host_rdata_o = glob_q[g_roff[2:1]][15:8];
        else
          host_rdata_o = glob_q[g_roff[2:1]][7:0];
      end
      REG_YY_L:
        host_rdata_o = public_yy_i[7:0];
      REG_YY_H:
        host_rdata_o = {7'b0, public_yy_i[8]};
      [TILE_BASE:TILE_LAST]:
        host_rdata_o = tile_rdata_i;
      default:
        host_rdata_o = 8'hff;
    endcase
  end

endmodule

// ==== design/video_timing.sv ====
`timescale 1ns/1ps

module video_timing
  import vga_pkg::*;
#(
  parameter int H_TOTAL        = 1040,
  parameter int H_ACTIVE       = 800,
  parameter int H_SYNC_START   = 861,
  parameter int H_SYNC_LEN     = 120,
  parameter int V_TOTAL        = 666,
  parameter int V_ACTIVE_START = 63,
  parameter int V_ACTIVE       = 600,
  parameter int V_SYNC_START   = 35,
  parameter int V_SYNC_LEN     = 6
)
(
  input  logic       vga_clk,
  input  logic       arst_n_i,
  output timing_t    timing_o,
  output byte_t      frames_o,
  output logic       vblank_o,
  output logic [8:0] public_yy_o
);

  localparam hcount_t H_LAST      = hcount_t'(H_TOTAL - 1);
  localparam hcount_t H_ACT_END   = hcount_t'(H_ACTIVE);
  localparam hcount_t H_SYNC_FROM = hcount_t'(H_SYNC_START);
  localparam hcount_t H_SYNC_TO   = hcount_t'(H_SYNC_START + H_SYNC_LEN);
  localparam vcount_t V_LAST      = vcount_t'(V_TOTAL - 1);
  localparam vcount_t V_ACT_FROM  = vcount_t'(V_ACTIVE_START);
  localparam vcount_t V_ACT_TO    = vcount_t'(V_ACTIVE_START + V_ACTIVE);
  localparam vcount_t V_SYNC_FROM = vcount_t'(V_SYNC_START);
  localparam vcount_t V_SYNC_TO   = vcount_t'(V_SYNC_START + V_SYNC_LEN);

  hcount_t hcount_q;
  vcount_t vcount_q;
  byte_t   frames_q;
  logic    line_end;
  logic    frame_end;
  logic    v_window;
  vcount_t yy;

  assign line_end  = (hcount_q == H_LAST);
  assign frame_end = line_end && (vcount_q == V_LAST);

  always_ff @(posedge vga_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      hcount_q <= '0;
      vcount_q <= '0;
      frames_q <= '0;
    end
    else
    begin
      if (line_end)
        hcount_q <= '0;
      else
        hcount_q <= hcount_q + hcount_t'(1);

      if (frame_end)
      begin
        vcount_q <= '0;
        frames_q <= frames_q + byte_t'(1);
      end
      else if (line_end)
      begin
        vcount_q <= vcount_q + vcount_t'(1);
      end
    end
  end

  // row index inside the visible window
  assign v_window = (vcount_q >= V_ACT_FROM) && (vcount_q < V_ACT_TO);
  assign yy       = vcount_q - V_ACT_FROM;

  assign timing_o.hsync  = (hcount_q >= H_SYNC_FROM) && (hcount_q < H_SYNC_TO);
  assign timing_o.vsync  = (vcount_q >= V_SYNC_FROM) && (vcount_q < V_SYNC_TO);
  assign timing_o.active = v_window && (hcount_q < H_ACT_END);
  assign timing_o.vblank = !v_window;
  // half resolution coordinates, parity bits drive the dither
  assign timing_o.x_par  = hcount_q[0];
  assign timing_o.y_par  = yy[0];
  assign timing_o.col    = hcount_q[9:1];
  assign timing_o.row    = yy[9:1];

  assign frames_o    = frames_q;
  assign vblank_o    = !v_window;
  // host sees line 300 while blanked
  assign public_yy_o = v_window ? yy[9:1] : 9'd300;

endmodule

// ==== design/vga_pkg.sv ====
package vga_pkg;

  // widths that carry a meaning
  typedef logic [14:0] color15_t;
  typedef logic [15:0] matte16_t;
  typedef logic [4:0]  chan5_t;
  typedef logic [2:0]  chan3_t;
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;
  typedef logic [5:0]  host_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [1:0]  pix_idx_t;
  typedef logic [1:0]  dith_t;

  // host port, plain strobe write plus combinational read
  typedef struct packed {
    logic       wr;
    host_addr_t waddr;
    byte_t      wdata;
    host_addr_t raddr;
  } host_bus_t;

  // raster state of the current pixel
  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       active;
    logic       vblank;
    logic       x_par;
    logic       y_par;
    logic [8:0] col;
    logic [8:0] row;
  } timing_t;

  typedef struct packed {
    pix_idx_t idx;
    logic     x_par;
    logic     y_par;
  } pixel_t;

  typedef struct packed {
    color15_t        bg;
    matte16_t [3:0]  glob;
    logic     [1:0]  dith_en;
  } palette_t;

  localparam byte_t IDENT_VALUE    = 8'h6d;
  localparam byte_t REVISION_VALUE = 8'h21;

  // register map
  localparam host_addr_t REG_IDENT  = 6'h00;
  localparam host_addr_t REG_REV    = 6'h01;
  localparam host_addr_t REG_FRAMES = 6'h02;
  localparam host_addr_t REG_VBLANK = 6'h03;
  localparam host_addr_t REG_DITH   = 6'h0d;
  localparam host_addr_t REG_BG_L   = 6'h0e;
  localparam host_addr_t REG_BG_H   = 6'h0f;
  localparam host_addr_t REG_G0_L   = 6'h16;
  localparam host_addr_t REG_G3_H   = 6'h1d;
  localparam host_addr_t REG_YY_L   = 6'h1e;
  localparam host_addr_t REG_YY_H   = 6'h1f;
  localparam host_addr_t TILE_BASE  = 6'h20;
  localparam host_addr_t TILE_LAST  = 6'h2f;

  // reset values
  localparam color15_t BG_RESET = 15'b010000011110100;
  localparam matte16_t [3:0] GLOB_RESET = {16'h8000, 16'h8000, 16'h8000, 16'hffff};
  localparam logic [1:0] DITH_RESET = 2'b11;

endpackage
